// File: hw/nocPkg.sv
package nocPkg;

  localparam int numPorts = 5;
  localparam int flitWidth = 32;
  localparam int idWidth = 3;
  localparam int lenWidth = 12;

  // flit kinds, carried in the top bits of every word
  localparam logic [idWidth-1:0] flitIdle = 3'd0;
  localparam logic [idWidth-1:0] flitHead = 3'd1;
  localparam logic [idWidth-1:0] flitBody = 3'd2;
  localparam logic [idWidth-1:0] flitTail = 3'd3;

  // one-hot arbiter states, bit 0 is idle and ports follow as L N E W S
  localparam logic [numPorts:0] grantIdle = 6'b000001;
  localparam logic [numPorts:0] grantL = 6'b000010;
  localparam logic [numPorts:0] grantN = 6'b000100;
  localparam logic [numPorts:0] grantE = 6'b001000;
  localparam logic [numPorts:0] grantW = 6'b010000;
  localparam logic [numPorts:0] grantS = 6'b100000;

  // one flit word seen as a header or as a body word
  typedef union packed {
    struct packed {
      logic [idWidth-1:0] kind;
      logic [lenWidth-1:0] len; // cycle budget for the arbiter
      logic [flitWidth-idWidth-lenWidth-1:0] spare;
    } head;
    struct packed {
      logic [idWidth-1:0] kind;
      logic [flitWidth-idWidth-1:0] payload;
    } body;
  } flitWord;

endpackage

// File: hw/inputPort.sv
`timescale 1ns/1ps

module inputPort (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::flitWidth-1:0] flitIn,
  input  logic flitValid,
  output logic [nocPkg::flitWidth-1:0] flit,
  output logic [nocPkg::idWidth-1:0] flitId,
  output logic [nocPkg::lenWidth-1:0] length,
  output logic req,
  output logic flitCaptured
);

  nocPkg::flitWord inWord;

  assign inWord = flitIn;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flit <= '0;
      flitId <= nocPkg::flitIdle;
      req <= 1'b0;
      flitCaptured <= 1'b0;
    end
    else
    begin
      flitCaptured <= flitValid;
      if (flitValid)
      begin
        flit <= flitIn;
        flitId <= inWord.body.kind;
        case (inWord.body.kind)
          nocPkg::flitHead: req <= 1'b1; // packet opens
          nocPkg::flitTail: req <= 1'b0;
          nocPkg::flitIdle, nocPkg::flitBody: req <= req;
          default: req <= req;
        endcase
      end
      else
      begin
        // no stale header left for the timer to latch
        flitId <= nocPkg::flitIdle;
      end
    end
  end

  // budget field, only meaningful when flitId says header
  always_ff @(posedge clk)
  begin
    if (flitValid)
      length <= inWord.head.len;
  end

endmodule

// File: hw/portTimer.sv
`timescale 1ns/1ps

module portTimer (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::idWidth-1:0] flitId,
  input  logic [nocPkg::lenWidth-1:0] length,
  input  logic runTimer,
  output logic timesUp
);

  logic [nocPkg::lenWidth-1:0] budget;
  logic [nocPkg::lenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == nocPkg::flitHead)
        budget <= length; // new packet, new budget
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == budget);

endmodule

// File: hw/switchArbiter.sv
`timescale 1ns/1ps

module switchArbiter (
  input  logic clk,
  input  logic rst,
  input  logic lReq,
  input  logic nReq,
  input  logic eReq,
  input  logic wReq,
  input  logic sReq,
  input  logic [nocPkg::idWidth-1:0] lFlitId,
  input  logic [nocPkg::idWidth-1:0] nFlitId,
  input  logic [nocPkg::idWidth-1:0] eFlitId,
  input  logic [nocPkg::idWidth-1:0] wFlitId,
  input  logic [nocPkg::idWidth-1:0] sFlitId,
  input  logic [nocPkg::lenWidth-1:0] lLength,
  input  logic [nocPkg::lenWidth-1:0] nLength,
  input  logic [nocPkg::lenWidth-1:0] eLength,
  input  logic [nocPkg::lenWidth-1:0] wLength,
  input  logic [nocPkg::lenWidth-1:0] sLength,
  output logic [nocPkg::numPorts:0] grant
);

  logic [nocPkg::numPorts-1:0] reqVec;
  logic [nocPkg::numPorts-1:0] runTimer;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::idWidth-1:0] idVec [nocPkg::numPorts];
  logic [nocPkg::lenWidth-1:0] lenVec [nocPkg::numPorts];
  logic [nocPkg::numPorts:0] nextGrant;

  // index 0 is L through index 4 for S
  assign reqVec = {sReq, wReq, eReq, nReq, lReq};
  assign idVec = '{lFlitId, nFlitId, eFlitId, wFlitId, sFlitId};
  assign lenVec = '{lLength, nLength, eLength, wLength, sLength};

  // first requester scanning upward from start, wrapping past S
  function automatic logic [nocPkg::numPorts:0] pickNext(
    input logic [nocPkg::numPorts-1:0] reqs,
    input int unsigned start
  );
    logic [nocPkg::numPorts:0] pick;
    int unsigned idx;
    logic found;
    pick = nocPkg::grantIdle;
    found = 1'b0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      idx = (start + i) % nocPkg::numPorts;
      if (!found && reqs[idx])
      begin
        pick = nocPkg::grantL << idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : genTimer
    // holder keeps the link while requesting and within budget
    assign runTimer[p] = (grant == (nocPkg::grantL << p)) && reqVec[p] && !timesUp[p];

    portTimer timer (
      .clk(clk),
      .rst(rst),
      .flitId(idVec[p]),
      .length(lenVec[p]),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  always_comb
  begin
    case (grant)
      nocPkg::grantIdle: nextGrant = pickNext(reqVec, 0);
      nocPkg::grantL: nextGrant = runTimer[0] ? nocPkg::grantL : pickNext(reqVec, 1);
      nocPkg::grantN: nextGrant = runTimer[1] ? nocPkg::grantN : pickNext(reqVec, 2);
      nocPkg::grantE: nextGrant = runTimer[2] ? nocPkg::grantE : pickNext(reqVec, 3);
      nocPkg::grantW: nextGrant = runTimer[3] ? nocPkg::grantW : pickNext(reqVec, 4);
      nocPkg::grantS: nextGrant = runTimer[4] ? nocPkg::grantS : pickNext(reqVec, 0);
      default: nextGrant = nocPkg::grantIdle; // illegal code recovers
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= nocPkg::grantIdle;
    else
      grant <= nextGrant;
  end

endmodule

// File: hw/flitSelector.sv
`timescale 1ns/1ps

module flitSelector (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts:0] grant,
  input  logic [nocPkg::flitWidth-1:0] lFlit,
  input  logic [nocPkg::flitWidth-1:0] nFlit,
  input  logic [nocPkg::flitWidth-1:0] eFlit,
  input  logic [nocPkg::flitWidth-1:0] wFlit,
  input  logic [nocPkg::flitWidth-1:0] sFlit,
  input  logic lValid,
  input  logic nValid,
  input  logic eValid,
  input  logic wValid,
  input  logic sValid,
  output logic [nocPkg::flitWidth-1:0] flitOut,
  output logic flitOutValid
);

  logic [nocPkg::flitWidth-1:0] chosenFlit;
  logic chosenValid;

  always_comb
  begin
    chosenFlit = flitOut; // link holds its last word when idle
    chosenValid = 1'b0;
    case (grant)
      nocPkg::grantL:
      begin
        chosenFlit = lFlit;
        chosenValid = lValid;
      end
      nocPkg::grantN:
      begin
        chosenFlit = nFlit;
        chosenValid = nValid;
      end
      nocPkg::grantE:
      begin
        chosenFlit = eFlit;
        chosenValid = eValid;
      end
      nocPkg::grantW:
      begin
        chosenFlit = wFlit;
        chosenValid = wValid;
      end
      nocPkg::grantS:
      begin
        chosenFlit = sFlit;
        chosenValid = sValid;
      end
      default: chosenValid = 1'b0; // idle or illegal grant
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitOut <= '0;
      flitOutValid <= 1'b0;
    end
    else
    begin
      flitOut <= chosenFlit;
      flitOutValid <= chosenValid;
    end
  end

endmodule

// File: hw/routerOutputChannel.sv
`timescale 1ns/1ps

module routerOutputChannel (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::flitWidth-1:0] lFlitIn,
  input  logic [nocPkg::flitWidth-1:0] nFlitIn,
  input  logic [nocPkg::flitWidth-1:0] eFlitIn,
  input  logic [nocPkg::flitWidth-1:0] wFlitIn,
  input  logic [nocPkg::flitWidth-1:0] sFlitIn,
  input  logic lFlitValid,
  input  logic nFlitValid,
  input  logic eFlitValid,
  input  logic wFlitValid,
  input  logic sFlitValid,
  output logic [nocPkg::numPorts:0] grant,
  output logic [nocPkg::flitWidth-1:0] flitOut,
  output logic flitOutValid
);

  logic [nocPkg::flitWidth-1:0] lFlit, nFlit, eFlit, wFlit, sFlit;
  logic [nocPkg::idWidth-1:0] lFlitId, nFlitId, eFlitId, wFlitId, sFlitId;
  logic [nocPkg::lenWidth-1:0] lLength, nLength, eLength, wLength, sLength;
  logic lReq, nReq, eReq, wReq, sReq;
  logic lCaptured, nCaptured, eCaptured, wCaptured, sCaptured;

  inputPort lPort (
    .clk(clk), .rst(rst), .flitIn(lFlitIn), .flitValid(lFlitValid), .flit(lFlit),
    .flitId(lFlitId), .length(lLength), .req(lReq), .flitCaptured(lCaptured)
  );

  inputPort nPort (
    .clk(clk), .rst(rst), .flitIn(nFlitIn), .flitValid(nFlitValid), .flit(nFlit),
    .flitId(nFlitId), .length(nLength), .req(nReq), .flitCaptured(nCaptured)
  );

  inputPort ePort (
    .clk(clk), .rst(rst), .flitIn(eFlitIn), .flitValid(eFlitValid), .flit(eFlit),
    .flitId(eFlitId), .length(eLength), .req(eReq), .flitCaptured(eCaptured)
  );

  inputPort wPort (
    .clk(clk), .rst(rst), .flitIn(wFlitIn), .flitValid(wFlitValid), .flit(wFlit),
    .flitId(wFlitId), .length(wLength), .req(wReq), .flitCaptured(wCaptured)
  );

  inputPort sPort (
    .clk(clk), .rst(rst), .flitIn(sFlitIn), .flitValid(sFlitValid), .flit(sFlit),
    .flitId(sFlitId), .length(sLength), .req(sReq), .flitCaptured(sCaptured)
  );

  switchArbiter arbiter (
    .clk(clk), .rst(rst),
    .lReq(lReq), .nReq(nReq), .eReq(eReq), .wReq(wReq), .sReq(sReq),
    .lFlitId(lFlitId), .nFlitId(nFlitId), .eFlitId(eFlitId),
    .wFlitId(wFlitId), .sFlitId(sFlitId),
    .lLength(lLength), .nLength(nLength), .eLength(eLength),
    .wLength(wLength), .sLength(sLength),
    .grant(grant)
  );

  flitSelector selector (
    .clk(clk), .rst(rst), .grant(grant),
    .lFlit(lFlit), .nFlit(nFlit), .eFlit(eFlit), .wFlit(wFlit), .sFlit(sFlit),
    .lValid(lCaptured), .nValid(nCaptured), .eValid(eCaptured),
    .wValid(wCaptured), .sValid(sCaptured),
    .flitOut(flitOut), .flitOutValid(flitOutValid)
  );

endmodule

// File: tests/tbRouterOutputChannel.sv
`timescale 1ns/1ps

module tbRouterOutputChannel;

  localparam int numCycles = 36;
  localparam int wordsPerLine = 9; // valid, five flits, grant, out valid, out flit
  localparam int lastWord = numCycles * wordsPerLine - 1;
  localparam int cycleLimit = numCycles + 20;

  logic clk;
  logic rst;
  logic [nocPkg::flitWidth-1:0] lFlitIn, nFlitIn, eFlitIn, wFlitIn, sFlitIn;
  logic lFlitValid, nFlitValid, eFlitValid, wFlitValid, sFlitValid;
  logic [nocPkg::numPorts:0] grant;
  logic [nocPkg::flitWidth-1:0] flitOut;
  logic flitOutValid;

  logic [31:0] patMem [numCycles*wordsPerLine];
  int lineIdx = 0;
  int cycleCount = 0;

  routerOutputChannel i_dut (
    .clk(clk), .rst(rst),
    .lFlitIn(lFlitIn), .nFlitIn(nFlitIn), .eFlitIn(eFlitIn),
    .wFlitIn(wFlitIn), .sFlitIn(sFlitIn),
    .lFlitValid(lFlitValid), .nFlitValid(nFlitValid), .eFlitValid(eFlitValid),
    .wFlitValid(wFlitValid), .sFlitValid(sFlitValid),
    .grant(grant), .flitOut(flitOut), .flitOutValid(flitOutValid)
  );

  always #2 clk = ~clk;

  // guard against a stalled run
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout after %0d cycles before the patterns were done", cycleLimit);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // marks words the pattern file never wrote
  function automatic logic [31:0] fillWord(input int addr);
    return 32'hf0000000 | addr;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
    input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED: %s at pattern line %0d got 0x%h expected 0x%h",
        name, lineIdx, actual, expected);
      $display("TB FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic applyLine(input int idx);
    int base;
    base = idx * wordsPerLine;
    lFlitValid = patMem[base][0];
    nFlitValid = patMem[base][1];
    eFlitValid = patMem[base][2];
    wFlitValid = patMem[base][3];
    sFlitValid = patMem[base][4];
    lFlitIn = patMem[base + 1];
    nFlitIn = patMem[base + 2];
    eFlitIn = patMem[base + 3];
    wFlitIn = patMem[base + 4];
    sFlitIn = patMem[base + 5];
  endtask

  task automatic checkLine(input int idx);
    int base;
    logic expValid;
    base = idx * wordsPerLine;
    expValid = patMem[base + 7][0];
    checkValue("grant", {26'b0, grant}, patMem[base + 6]);
    checkValue("flitOutValid", {31'b0, flitOutValid}, patMem[base + 7]);
    if (expValid)
      checkValue("flitOut", flitOut, patMem[base + 8]); // don't care while invalid
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    for (int i = 0; i <= lastWord; i++)
      patMem[i] = fillWord(i);
    $readmemh("tests/routerPatterns.hex", patMem);
    if (patMem[lastWord] === fillWord(lastWord) || $isunknown(patMem[lastWord]))
    begin
      $display("pattern file tests/routerPatterns.hex is missing or has too few lines");
      $display("TB FAILED");
      $fatal(1, "bad pattern file");
    end
    // all-zero line for the reset cycles
    lFlitValid = 1'b0;
    nFlitValid = 1'b0;
    eFlitValid = 1'b0;
    wFlitValid = 1'b0;
    sFlitValid = 1'b0;
    lFlitIn = '0;
    nFlitIn = '0;
    eFlitIn = '0;
    wFlitIn = '0;
    sFlitIn = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (lineIdx = 0; lineIdx < numCycles; lineIdx++)
    begin
      applyLine(lineIdx);
      #2;
      checkLine(lineIdx); // just before the next edge
      @(posedge clk);
      #1;
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: tests/routerPatterns.hex
// each line is one cycle with valid bits (bit 0 L up to bit 4 S) and the L N E W S input flits
// followed by expected grant and flitOutValid and flitOut (flitOut only compared when valid)
00 00000000 00000000 00000000 00000000 00000000 01 0 00000000
00 00000000 00000000 00000000 00000000 00000000 01 0 00000000
00 00000000 00000000 00000000 00000000 00000000 01 0 00000000
15 20100103 00000000 20100303 00000000 20100503 01 0 00000000
1d 40000104 00000000 40000304 40000404 40000504 01 0 00000000
15 40000105 00000000 40000305 00000000 40000505 02 0 00000000
15 60000106 00000000 40000306 00000000 40000506 02 1 40000104
14 00000000 00000000 40000307 00000000 40000507 02 1 40000105
15 20040108 00000000 40000308 00000000 40000508 08 1 60000106
15 40000109 00000000 60000309 00000000 40000509 08 1 40000307
19 4000010a 00000000 00000000 4000040a 4000050a 08 1 40000308
11 4000010b 00000000 00000000 00000000 4000050b 20 1 60000309
13 4000010c 2010020c 00000000 00000000 4000050c 20 1 4000050a
13 4000010d 4000020d 00000000 00000000 6000050d 20 1 4000050b
03 4000010e 4000020e 00000000 00000000 00000000 20 1 4000050c
03 4000010f 4000020f 00000000 00000000 00000000 02 1 6000050d
03 40000110 40000210 00000000 00000000 00000000 02 1 4000010e
03 40000111 40000211 00000000 00000000 00000000 02 1 4000010f
03 40000112 40000212 00000000 00000000 00000000 04 1 40000110
03 40000113 40000213 00000000 00000000 00000000 04 1 40000211
03 40000114 60000214 00000000 00000000 00000000 04 1 40000212
01 40000115 00000000 00000000 00000000 00000000 04 1 40000213
01 40000116 00000000 00000000 00000000 00000000 02 1 60000214
01 60000117 00000000 00000000 00000000 00000000 02 1 40000115
00 00000000 00000000 00000000 00000000 00000000 02 1 40000116
00 00000000 00000000 00000000 00000000 00000000 01 1 60000117
00 00000000 00000000 00000000 00000000 00000000 01 0 00000000
08 00000000 00000000 00000000 2002041b 00000000 01 0 00000000
08 00000000 00000000 00000000 4000041c 00000000 01 0 00000000
08 00000000 00000000 00000000 4000041d 00000000 10 0 00000000
08 00000000 00000000 00000000 4000041e 00000000 10 1 4000041c
08 00000000 00000000 00000000 6000041f 00000000 10 1 4000041d
00 00000000 00000000 00000000 00000000 00000000 10 1 4000041e
00 00000000 00000000 00000000 00000000 00000000 01 1 6000041f
00 00000000 00000000 00000000 00000000 00000000 01 0 00000000
00 00000000 00000000 00000000 00000000 00000000 01 0 00000000

// File: sim.f
hw/nocPkg.sv
hw/inputPort.sv
hw/portTimer.sv
hw/switchArbiter.sv
hw/flitSelector.sv
hw/routerOutputChannel.sv
tests/tbRouterOutputChannel.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
TOP = tbRouterOutputChannel
FILELIST = sim.f
OBJDIR = obj_dir

SIM = $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM) tests/routerPatterns.hex
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
